/* Makefile */
# Verilator build and run of the decode stage testbench
TOP := tb_decode_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f rv_decode.f -Mdir obj_dir

# Passes only when the pass line shows up in the simulation output
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | \
		awk '{ print } /RESULT: PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* hw/decode_stage.sv */
// Decode stage top level with micro-op assembly, illegal detect and stalled output register
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import rv_isa_pkg::*, uop_pkg::*;
(
    input  logic   clk_g,
    input  logic   rst_g,
    input  logic   instr_valid,
    input  instr_t instr,
    input  addr_t  instr_pc,
    output logic   ready,
    input  logic   stall,
    input  logic   flush,
    output uop_t   uop,
    output logic   exc_illegal,
    output addr_t  exc_pc
);

    imm_t      imm;
    dec_ctrl_t ctrl;
    logic      live;
    logic      illegal;
    uop_t      uop_next;
    uop_t      uop_q;

    // ========================================
    // Combinational decode
    // ========================================
    imm_gen i_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    op_decode i_op_decode (
        .instr (instr),
        .ctrl  (ctrl)
    );

    assign live    = instr_valid && !flush;
    assign illegal = (ctrl.func == func_none);

    // Exception is reported in the decode cycle itself
    assign exc_illegal = live && illegal;
    assign exc_pc      = instr_pc;

    // Input is only accepted when not stalled
    assign ready = !stall;

    always_comb begin
        uop_next.valid      = live && !illegal;
        uop_next.unit       = ctrl.unit;
        uop_next.func       = ctrl.func;
        uop_next.op1_sel    = ctrl.op1_sel;
        uop_next.op2_sel    = ctrl.op2_sel;
        uop_next.imm        = imm;
        uop_next.rd         = reg_idx_t'(instr[rd_lsb +: reg_idx_width]);
        uop_next.rs1        = reg_idx_t'(instr[rs1_lsb +: reg_idx_width]);
        uop_next.rs2        = reg_idx_t'(instr[rs2_lsb +: reg_idx_width]);
        uop_next.load       = ctrl.load;
        uop_next.store      = ctrl.store;
        uop_next.mem_size   = ctrl.mem_size;
        uop_next.mem_signed = ctrl.mem_signed;
        uop_next.pc         = instr_pc;
    end

    // ========================================
    // Output register
    // ========================================
    // Payload loads whenever the stage advances, reset only drops valid
    always_ff @(posedge clk_g) begin
        if (!stall) begin
            uop_q <= uop_next;
        end
        if (rst_g) begin
            uop_q.valid <= 1'b0;
        end
    end

    assign uop = uop_q;

endmodule

`default_nettype wire

/* hw/imm_gen.sv */
// Immediate generator for the I, U, J, S and B formats with opcode select
`timescale 1ns/10ps
`default_nettype none

module imm_gen
    import rv_isa_pkg::*, uop_pkg::*;
(
    input  instr_t instr,
    output imm_t   imm
);

    opcode_t opcode;
    imm_t    i_imm;
    imm_t    u_imm;
    imm_t    j_imm;
    imm_t    s_imm;
    imm_t    b_imm;

    assign opcode = opcode_t'(instr[opcode_lsb +: opcode_width]);

    // All formats take their sign from bit 31
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign u_imm = {instr[31:12], 12'b0};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // Jump and branch offsets are in halfwords, bit 0 is implied zero
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (opcode)
            op_load,
            op_jalr,
            op_imm:    imm = i_imm;
            op_lui,
            op_auipc:  imm = u_imm;
            op_jal:    imm = j_imm;
            op_branch: imm = b_imm;
            op_store:  imm = s_imm;
            // R-type and unknown opcodes
            default:   imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/op_decode.sv */
// Opcode decoder mapping opcode, funct3 and funct7 to unit, function, operand selects and memory flags
`timescale 1ns/10ps
`default_nettype none

module op_decode
    import rv_isa_pkg::*, uop_pkg::*;
(
    input  instr_t    instr,
    output dec_ctrl_t ctrl
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = opcode_t'(instr[opcode_lsb +: opcode_width]);
    assign funct3 = instr[funct3_lsb +: funct3_width];
    assign funct7 = instr[funct7_lsb +: funct7_width];

    // Integer ALU table shared by OP-IMM and OP
    // alt is funct7 bit 5, sub only exists in the register form
    function automatic func_t alu_func(input funct3_t f3, input logic alt, input logic sub_ok);
        func_t f;
        case (f3)
            3'd0:    f = (sub_ok && alt) ? func_sub : func_add;
            3'd1:    f = func_sll;
            3'd2:    f = func_slt;
            3'd3:    f = func_sltu;
            3'd4:    f = func_xor;
            3'd5:    f = alt ? func_sra : func_srl;
            3'd6:    f = func_or;
            default: f = func_and;
        endcase
        return f;
    endfunction

    // ========================================
    // Decode tree
    // ========================================
    always_comb begin
        // Anything not matched below stays func_none
        ctrl = '0;

        case (opcode)
            op_lui: begin
                ctrl.unit    = unit_alu;
                ctrl.func    = func_lui;
                ctrl.op1_sel = op1_zero;
                ctrl.op2_sel = op2_imm;
            end
            op_auipc: begin
                ctrl.unit    = unit_alu;
                ctrl.func    = func_auipc;
                ctrl.op1_sel = op1_pc;
                ctrl.op2_sel = op2_imm;
            end
            op_imm: begin
                ctrl.unit    = unit_alu;
                ctrl.func    = alu_func(funct3, funct7[5], 1'b0);
                ctrl.op2_sel = op2_imm;
            end
            op_reg: begin
                if (funct7[0]) begin
                    // M extension, upper half of funct3 goes to the divider
                    ctrl.unit = funct3[2] ? unit_div : unit_mul;
                    case (funct3)
                        3'd0:    ctrl.func = func_mul;
                        3'd1:    ctrl.func = func_mulh;
                        3'd2:    ctrl.func = func_mulhsu;
                        3'd3:    ctrl.func = func_mulhu;
                        3'd4:    ctrl.func = func_div;
                        3'd5:    ctrl.func = func_divu;
                        3'd6:    ctrl.func = func_rem;
                        default: ctrl.func = func_remu;
                    endcase
                end else begin
                    ctrl.unit = unit_alu;
                    ctrl.func = alu_func(funct3, funct7[5], 1'b1);
                end
            end
            op_jal: begin
                ctrl.unit    = unit_branch;
                ctrl.func    = func_jal;
                ctrl.op1_sel = op1_pc;
                ctrl.op2_sel = op2_imm;
            end
            op_jalr: begin
                ctrl.unit    = unit_branch;
                ctrl.func    = func_jalr;
                ctrl.op2_sel = op2_imm;
            end
            op_branch: begin
                ctrl.unit = unit_branch;
                case (funct3)
                    3'd0:    ctrl.func = func_beq;
                    3'd1:    ctrl.func = func_bne;
                    3'd4:    ctrl.func = func_blt;
                    3'd5:    ctrl.func = func_bge;
                    3'd6:    ctrl.func = func_bltu;
                    3'd7:    ctrl.func = func_bgeu;
                    default: ctrl.func = func_none;
                endcase
            end
            op_load: begin
                ctrl.unit    = unit_mem;
                ctrl.load    = 1'b1;
                ctrl.op2_sel = op2_imm;
                case (funct3)
                    3'd0: begin
                        ctrl.func       = func_lb;
                        ctrl.mem_size   = mem_byte;
                        ctrl.mem_signed = 1'b1;
                    end
                    3'd1: begin
                        ctrl.func       = func_lh;
                        ctrl.mem_size   = mem_half;
                        ctrl.mem_signed = 1'b1;
                    end
                    3'd2: begin
                        ctrl.func       = func_lw;
                        ctrl.mem_size   = mem_word;
                        ctrl.mem_signed = 1'b1;
                    end
                    3'd4: begin
                        ctrl.func     = func_lbu;
                        ctrl.mem_size = mem_byte;
                    end
                    3'd5: begin
                        ctrl.func     = func_lhu;
                        ctrl.mem_size = mem_half;
                    end
                    default: ctrl.func = func_none;
                endcase
            end
            op_store: begin
                // Operands stay rs1 and rs2, the offset rides in imm
                ctrl.unit  = unit_mem;
                ctrl.store = 1'b1;
                case (funct3)
                    3'd0: begin
                        ctrl.func     = func_sb;
                        ctrl.mem_size = mem_byte;
                    end
                    3'd1: begin
                        ctrl.func     = func_sh;
                        ctrl.mem_size = mem_half;
                    end
                    3'd2: begin
                        ctrl.func     = func_sw;
                        ctrl.mem_size = mem_word;
                    end
                    default: ctrl.func = func_none;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_isa_pkg.sv */
// RV32 instruction field positions and widths, opcode enum, instruction vector types
`default_nettype none

package rv_isa_pkg;

    // Base vector widths
    localparam int instr_width   = 32;
    localparam int addr_width    = 32;
    localparam int reg_idx_width = 5;

    // Field widths
    localparam int opcode_width = 7;
    localparam int funct3_width = 3;
    localparam int funct7_width = 7;

    // Field positions (lowest bit of each field)
    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    typedef logic [instr_width-1:0]   instr_t;
    typedef logic [addr_width-1:0]    addr_t;
    typedef logic [reg_idx_width-1:0] reg_idx_t;
    typedef logic [funct3_width-1:0]  funct3_t;
    typedef logic [funct7_width-1:0]  funct7_t;

    // Major opcodes handled by the decoder
    // SYSTEM and MISC-MEM are absent and fall out as unknown
    typedef enum logic [opcode_width-1:0] {
        op_load   = 7'h03,
        op_imm    = 7'h13,
        op_auipc  = 7'h17,
        op_store  = 7'h23,
        op_reg    = 7'h33,
        op_lui    = 7'h37,
        op_branch = 7'h63,
        op_jalr   = 7'h67,
        op_jal    = 7'h6f
    } opcode_t;

endpackage

`default_nettype wire

/* hw/uop_pkg.sv */
// Micro-op enums (unit, function, operand selects, memory size), decoder control and micro-op structs
`default_nettype none

package uop_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        unit_alu    = 3'd0,
        unit_mul    = 3'd1,
        unit_div    = 3'd2,
        unit_branch = 3'd3,
        unit_mem    = 3'd4
    } exec_unit_t;

    // Zero is reserved, it flags an illegal instruction
    typedef enum logic [5:0] {
        func_none = 6'd0,
        func_lui, func_auipc,
        func_add, func_sub, func_sll, func_slt, func_sltu,
        func_xor, func_srl, func_sra, func_or, func_and,
        func_mul, func_mulh, func_mulhsu, func_mulhu,
        func_div, func_divu, func_rem, func_remu,
        func_jal, func_jalr,
        func_beq, func_bne, func_blt, func_bge, func_bltu, func_bgeu,
        func_lb, func_lh, func_lw, func_lbu, func_lhu,
        func_sb, func_sh, func_sw
    } func_t;

    typedef enum logic [1:0] {
        op1_rs1  = 2'd0,
        op1_zero = 2'd1,
        op1_pc   = 2'd2
    } op1_sel_t;

    typedef enum logic {
        op2_rs2 = 1'b0,
        op2_imm = 1'b1
    } op2_sel_t;

    typedef enum logic [1:0] {
        mem_none = 2'd0,
        mem_byte = 2'd1,
        mem_half = 2'd2,
        mem_word = 2'd3
    } mem_size_t;

    typedef logic [31:0] imm_t;

    // Control fields produced by the opcode decoder
    typedef struct packed {
        exec_unit_t unit;
        func_t      func;
        op1_sel_t   op1_sel;
        op2_sel_t   op2_sel;
        logic       load;
        logic       store;
        mem_size_t  mem_size;
        logic       mem_signed;
    } dec_ctrl_t;

    // Micro-op handed to the issue stage
    typedef struct packed {
        logic       valid;
        exec_unit_t unit;
        func_t      func;
        op1_sel_t   op1_sel;
        op2_sel_t   op2_sel;
        imm_t       imm;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic       load;
        logic       store;
        mem_size_t  mem_size;
        logic       mem_signed;
        addr_t      pc;
    } uop_t;

endpackage

`default_nettype wire

/* rv_decode.f */
hw/rv_isa_pkg.sv
hw/uop_pkg.sv
hw/imm_gen.sv
hw/op_decode.sv
hw/decode_stage.sv
tb/decode_checker.sv
tb/decode_scoreboard.sv
tb/tb_decode_stage.sv

/* tb/decode_checker.sv */
// Bound assertions for reset, stall hold, exception qualification and ready of the decode stage
`timescale 1ns/10ps
`default_nettype none

module decode_checker
    import uop_pkg::*;
(
    input logic clk_g,
    input logic rst_g,
    input logic instr_valid,
    input logic stall,
    input logic flush,
    input logic ready,
    input logic exc_illegal,
    input uop_t uop
);

    // Number of failed assertions so far
    int assert_failures = 0;

    // Valid drops in the cycle after a reset edge
    reset_clears_valid: assert property (@(posedge clk_g) rst_g |=> !uop.valid)
        else begin
            assert_failures++;
            $error("uop.valid high in the cycle after reset");
        end

    // A stalled edge leaves the whole micro-op untouched
    stall_holds_uop: assert property (@(posedge clk_g) disable iff (rst_g)
        stall |=> $stable(uop))
        else begin
            assert_failures++;
            $error("uop changed across a stalled edge");
        end

    exc_needs_live: assert property (@(posedge clk_g) exc_illegal |-> (instr_valid && !flush))
        else begin
            assert_failures++;
            $error("exc_illegal raised without a live instruction");
        end

    ready_is_not_stall: assert property (@(posedge clk_g) ready == !stall)
        else begin
            assert_failures++;
            $error("ready does not follow the inverse of stall");
        end

endmodule

`default_nettype wire

/* tb/decode_scoreboard.sv */
// Decode scoreboard with reference decode, expected micro-op register and output comparison
`timescale 1ns/10ps
`default_nettype none

module decode_scoreboard
    import rv_isa_pkg::*, uop_pkg::*;
(
    input  logic   clk_g,
    input  logic   rst_g,
    input  logic   instr_valid,
    input  instr_t instr,
    input  addr_t  instr_pc,
    input  logic   stall,
    input  logic   flush,
    input  logic   ready,
    input  uop_t   uop,
    input  logic   exc_illegal,
    input  addr_t  exc_pc,
    output int     error_count,
    output int     check_count
);

    // funct3 lookup per group, func_none marks a hole in the encoding
    localparam func_t alu_funcs [0:7] = '{func_add, func_sll, func_slt, func_sltu,
                                          func_xor, func_srl, func_or, func_and};
    localparam func_t muldiv_funcs [0:7] = '{func_mul, func_mulh, func_mulhsu, func_mulhu,
                                             func_div, func_divu, func_rem, func_remu};
    localparam func_t branch_funcs [0:7] = '{func_beq, func_bne, func_none, func_none,
                                             func_blt, func_bge, func_bltu, func_bgeu};
    localparam func_t load_funcs [0:7] = '{func_lb, func_lh, func_lw, func_none,
                                           func_lbu, func_lhu, func_none, func_none};
    localparam func_t store_funcs [0:7] = '{func_sb, func_sh, func_sw, func_none,
                                            func_none, func_none, func_none, func_none};

    uop_t exp_next;
    uop_t exp_q;
    logic exp_exc;
    logic armed = 1'b0;
    int   exc_errors = 0;
    int   uop_errors = 0;
    int   exc_checks = 0;
    int   uop_checks = 0;

    // Sign-extends the low n bits of v
    function automatic imm_t sext(input imm_t v, input int n);
        imm_t top;
        top = imm_t'(1) << (n - 1);
        return ((v & ((top << 1) - 1)) ^ top) - top;
    endfunction

    // ========================================
    // Reference decode
    // ========================================
    function automatic uop_t expect_uop(input instr_t w, input addr_t pc);
        uop_t       e;
        logic [2:0] f3;
        logic       alt;
        imm_t       imm_i;
        f3    = w[14:12];
        alt   = w[30];
        imm_i = sext(32'(w[31:20]), 12);
        e     = '0;
        e.rd  = w[11:7];
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.pc  = pc;
        case (w[6:0])
            7'h37: begin
                e.func    = func_lui;
                e.op1_sel = op1_zero;
                e.op2_sel = op2_imm;
                e.imm     = {w[31:12], 12'h000};
            end
            7'h17: begin
                e.func    = func_auipc;
                e.op1_sel = op1_pc;
                e.op2_sel = op2_imm;
                e.imm     = {w[31:12], 12'h000};
            end
            7'h13: begin
                e.func    = (f3 == 3'd5 && alt) ? func_sra : alu_funcs[f3];
                e.op2_sel = op2_imm;
                e.imm     = imm_i;
            end
            7'h33: begin
                if (w[25]) begin
                    e.unit = unit_mul;
                    if (f3[2]) begin
                        e.unit = unit_div;
                    end
                    e.func = muldiv_funcs[f3];
                end else begin
                    e.func = alu_funcs[f3];
                    if (alt && f3 == 3'd0) begin
                        e.func = func_sub;
                    end
                    if (alt && f3 == 3'd5) begin
                        e.func = func_sra;
                    end
                end
            end
            7'h6f: begin
                e.unit    = unit_branch;
                e.func    = func_jal;
                e.op1_sel = op1_pc;
                e.op2_sel = op2_imm;
                e.imm     = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
            end
            7'h67: begin
                e.unit    = unit_branch;
                e.func    = func_jalr;
                e.op2_sel = op2_imm;
                e.imm     = imm_i;
            end
            7'h63: begin
                e.unit = unit_branch;
                e.func = branch_funcs[f3];
                e.imm  = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            end
            7'h03: begin
                e.unit       = unit_mem;
                e.func       = load_funcs[f3];
                e.op2_sel    = op2_imm;
                e.imm        = imm_i;
                e.load       = 1'b1;
                e.mem_size   = mem_size_t'(f3[1:0] + 2'd1);
                e.mem_signed = !f3[2];
            end
            7'h23: begin
                e.unit     = unit_mem;
                e.func     = store_funcs[f3];
                e.imm      = sext(32'({w[31:25], w[11:7]}), 12);
                e.store    = 1'b1;
                e.mem_size = mem_size_t'(f3[1:0] + 2'd1);
            end
            default: begin
                e.func = func_none;
            end
        endcase
        e.valid = (e.func != func_none);
        return e;
    endfunction

    // Prints a mismatch line and returns 1 when the values differ
    function automatic int differs(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
            return 1;
        end
        return 0;
    endfunction

    always_comb begin
        exp_next       = expect_uop(instr, instr_pc);
        exp_exc        = instr_valid && !flush && !exp_next.valid;
        exp_next.valid = exp_next.valid && instr_valid && !flush;
    end

    // Combinational outputs checked just as the edge samples them
    always @(posedge clk_g) begin
        int bad;
        bad = differs("ready", 32'(ready), 32'(!stall));
        bad += differs("exc_illegal", 32'(exc_illegal), 32'(exp_exc));
        bad += differs("exc_pc", exc_pc, instr_pc);
        exc_checks++;
        exc_errors += bad;
        armed <= 1'b1;
        if (rst_g) begin
            exp_q.valid <= 1'b0;
        end else if (!stall) begin
            exp_q <= exp_next;
        end
    end

    // Registered micro-op checked mid-cycle
    always @(negedge clk_g) begin
        int bad;
        if (armed) begin
            bad = differs("uop.valid", 32'(uop.valid), 32'(exp_q.valid));
            if (exp_q.valid && bad == 0) begin
                bad += differs("uop.unit", 32'(uop.unit), 32'(exp_q.unit));
                bad += differs("uop.func", 32'(uop.func), 32'(exp_q.func));
                bad += differs("uop.op1_sel", 32'(uop.op1_sel), 32'(exp_q.op1_sel));
                bad += differs("uop.op2_sel", 32'(uop.op2_sel), 32'(exp_q.op2_sel));
                bad += differs("uop.imm", uop.imm, exp_q.imm);
                bad += differs("uop.rd", 32'(uop.rd), 32'(exp_q.rd));
                bad += differs("uop.rs1", 32'(uop.rs1), 32'(exp_q.rs1));
                bad += differs("uop.rs2", 32'(uop.rs2), 32'(exp_q.rs2));
                bad += differs("uop.load", 32'(uop.load), 32'(exp_q.load));
                bad += differs("uop.store", 32'(uop.store), 32'(exp_q.store));
                bad += differs("uop.mem_size", 32'(uop.mem_size), 32'(exp_q.mem_size));
                bad += differs("uop.mem_signed", 32'(uop.mem_signed), 32'(exp_q.mem_signed));
                bad += differs("uop.pc", uop.pc, exp_q.pc);
            end
            uop_checks++;
            uop_errors += bad;
        end
    end

    assign error_count = exc_errors + uop_errors;
    assign check_count = exc_checks + uop_checks;

endmodule

`default_nettype wire

/* tb/tb_decode_stage.sv */
// Decode stage testbench top with clock, reset, random stimulus and checker binding
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage
    import rv_isa_pkg::*, uop_pkg::*;
();

    localparam int num_cycles  = 2000;
    localparam int drain_limit = 16;

    // Kept opcodes followed by SYSTEM and MISC-MEM
    // The last slot is replaced by a random opcode
    localparam logic [6:0] opcode_choices [0:11] = '{
        op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load,
        op_store, op_imm, op_reg, 7'h73, 7'h0f, 7'h00
    };

    int     seed;
    logic   clk_g;
    logic   rst_g;
    logic   instr_valid;
    instr_t instr;
    addr_t  instr_pc;
    logic   ready;
    logic   stall;
    logic   flush;
    uop_t   uop;
    logic   exc_illegal;
    addr_t  exc_pc;
    int     error_count;
    int     check_count;

    always #2 clk_g = ~clk_g;

    decode_stage i_dut (
        .clk_g       (clk_g),
        .rst_g       (rst_g),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .ready       (ready),
        .stall       (stall),
        .flush       (flush),
        .uop         (uop),
        .exc_illegal (exc_illegal),
        .exc_pc      (exc_pc)
    );

    decode_scoreboard i_scoreboard (
        .clk_g       (clk_g),
        .rst_g       (rst_g),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .stall       (stall),
        .flush       (flush),
        .ready       (ready),
        .uop         (uop),
        .exc_illegal (exc_illegal),
        .exc_pc      (exc_pc),
        .error_count (error_count),
        .check_count (check_count)
    );

    bind decode_stage decode_checker i_checker (
        .clk_g       (clk_g),
        .rst_g       (rst_g),
        .instr_valid (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .ready       (ready),
        .exc_illegal (exc_illegal),
        .uop         (uop)
    );

    // Random word with its opcode forced to one of the choices
    function automatic instr_t random_instr();
        instr_t     w;
        logic [3:0] pick;
        w    = $random(seed);
        pick = 4'($unsigned($random(seed)) % 12);
        if (pick != 4'd11) begin
            w[6:0] = opcode_choices[pick];
        end
        return w;
    endfunction

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        int n;
        int run_left;
        int other_errors;
        seed         = 32'h82188f8d;
        clk_g        = 1'b0;
        rst_g        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        instr_pc     = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        run_left     = 0;
        other_errors = 0;

        // Reset spans two rising edges
        repeat (2) @(posedge clk_g);
        @(negedge clk_g);
        rst_g = 1'b0;

        for (n = 0; n < num_cycles; n++) begin
            // Stall comes in runs of one to eight cycles
            if (run_left == 0) begin
                stall    = ($random(seed) & 3) == 0;
                run_left = 1 + ($random(seed) & 7);
            end
            run_left--;
            instr_valid = ($random(seed) & 7) != 0;
            flush       = ($random(seed) & 7) == 0;
            instr       = random_instr();
            instr_pc    = $random(seed) & ~32'h3;
            @(negedge clk_g);
        end

        // Idle inputs until the register drains
        stall       = 1'b0;
        instr_valid = 1'b0;
        flush       = 1'b0;
        for (n = 0; n < drain_limit && uop.valid; n++) begin
            @(negedge clk_g);
        end
        if (uop.valid) begin
            $display("Timeout: uop.valid still high %0d cycles after the inputs went idle",
                     drain_limit);
            other_errors++;
        end

        // Past the comparisons of this falling edge
        #1;

        $display("Errors: %0d value, %0d assertion, %0d other, over %0d checks",
                 error_count, i_dut.i_checker.assert_failures, other_errors, check_count);
        if (error_count == 0 && i_dut.i_checker.assert_failures == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
